/* common/gemm_pkg.sv */
// ##########################################################
// shared sizes, register map and types of the gemm DMA block
// modules pull this in with a wildcard import in their body
// ##########################################################
package gemm_pkg;

    // matrix and word geometry
    localparam int SA_WIDTH  = 4;
    localparam int ELEM_W    = 8;
    localparam int WORD_W    = 32;
    localparam int BUF_W     = SA_WIDTH * WORD_W;
    localparam int SEL_W     = 2;
    // beat index covers 16 results, length needs one more bit
    localparam int IDX_W     = 4;
    localparam int LEN_W     = 5;
    localparam int NUM_RES   = SA_WIDTH * SA_WIDTH;

    // scratch memory
    localparam int MEM_DEPTH = 64;
    localparam int MEM_AW    = 6;

    // apb register map
    localparam int APB_AW = 12;
    localparam logic [APB_AW-1:0] REG_CTRL     = 12'h000;
    localparam logic [APB_AW-1:0] REG_STATUS   = 12'h004;
    localparam logic [APB_AW-1:0] REG_A_BASE   = 12'h008;
    localparam logic [APB_AW-1:0] REG_B_BASE   = 12'h00C;
    localparam logic [APB_AW-1:0] REG_C_BASE   = 12'h010;
    // window runs 0x100..0x1FC, one word per 4 bytes
    localparam logic [APB_AW-1:0] MEM_WIN_BASE = 12'h100;

    // memory word: four int8 operands or one int32 result
    typedef union packed {
        logic [SA_WIDTH-1:0][ELEM_W-1:0] elem;
        logic signed [WORD_W-1:0]         res;
    } mem_word_u;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_A,
        LOAD_B,
        START_MM,
        WAIT_MM,
        STORE_C,
        FINISH
    } dma_state_e;

endpackage

/* logic/apb_regs.sv */
// ##########################################################
// apb slave of the accelerator: control, status, base regs
// and the host window onto scratch memory
// pready always high, reads are combinational
// ##########################################################
`timescale 1ns/1ns

module apb_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [gemm_pkg::APB_AW-1:0]   paddr_i,
    input  logic [gemm_pkg::WORD_W-1:0]   pwdata_i,
    output logic [gemm_pkg::WORD_W-1:0]   prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    output logic                          host_we_o,
    output logic [gemm_pkg::MEM_AW-1:0]   host_addr_o,
    output logic [gemm_pkg::WORD_W-1:0]   host_wdata_o,
    input  logic [gemm_pkg::WORD_W-1:0]   host_rdata_i,
    output logic                          start_o,
    output logic [gemm_pkg::MEM_AW-1:0]   a_base_o,
    output logic [gemm_pkg::MEM_AW-1:0]   b_base_o,
    output logic [gemm_pkg::MEM_AW-1:0]   c_base_o,
    input  logic                          busy_i,
    input  logic                          done_pulse_i
);
    import gemm_pkg::*;

    logic access, wr;
    logic is_ctrl, is_status, is_a, is_b, is_c, in_win;
    logic unmapped, fault;
    logic done_q;

    // access phase of a transfer
    assign access = psel_i & penable_i;
    assign wr     = access & pwrite_i;

    // register decode
    assign is_ctrl   = (paddr_i == REG_CTRL);
    assign is_status = (paddr_i == REG_STATUS);
    assign is_a      = (paddr_i == REG_A_BASE);
    assign is_b      = (paddr_i == REG_B_BASE);
    assign is_c      = (paddr_i == REG_C_BASE);
    // window: upper address bits match, low two bits ignored
    assign in_win = (paddr_i[APB_AW-1:MEM_AW+2] == MEM_WIN_BASE[APB_AW-1:MEM_AW+2]);
    assign unmapped = !(is_ctrl | is_status | is_a | is_b | is_c | in_win);

    // bad address, window while DMA owns memory, or STATUS write
    assign fault = unmapped | (in_win & busy_i) | (pwrite_i & is_status);

    assign pready_o  = 1'b1;
    assign pslverr_o = access & fault;

    // host side of scratch memory
    assign host_addr_o  = paddr_i[MEM_AW+1:2];
    assign host_wdata_o = pwdata_i;
    assign host_we_o    = wr & in_win & !busy_i;

    // start only taken while idle
    assign start_o = wr & is_ctrl & pwdata_i[0] & !busy_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_base_o <= '0;
            b_base_o <= '0;
            c_base_o <= '0;
            done_q   <= 1'b0;
        end else begin
            if (wr && is_a)
                a_base_o <= pwdata_i[MEM_AW-1:0];
            if (wr && is_b)
                b_base_o <= pwdata_i[MEM_AW-1:0];
            if (wr && is_c)
                c_base_o <= pwdata_i[MEM_AW-1:0];
            // sticky done, new run clears it
            if (start_o)
                done_q <= 1'b0;
            else if (done_pulse_i)
                done_q <= 1'b1;
        end
    end

    // read mux, faulting reads return zero
    always_comb begin
        prdata_o = '0;
        if (!fault) begin
            if (is_status)
                prdata_o = {{(WORD_W-2){1'b0}}, done_q, busy_i};
            else if (is_a)
                prdata_o = {{(WORD_W-MEM_AW){1'b0}}, a_base_o};
            else if (is_b)
                prdata_o = {{(WORD_W-MEM_AW){1'b0}}, b_base_o};
            else if (is_c)
                prdata_o = {{(WORD_W-MEM_AW){1'b0}}, c_base_o};
            else if (in_win)
                prdata_o = host_rdata_i;
        end
    end

endmodule

/* logic/scratch_mem.sv */
// ##########################################################
// on-chip word memory shared by host and DMA
// async reads on both ports, DMA write wins a collision
// ##########################################################
`timescale 1ns/1ns

module scratch_mem (
    input  logic                         clk,
    input  logic                         host_we_i,
    input  logic [gemm_pkg::MEM_AW-1:0]  host_addr_i,
    input  logic [gemm_pkg::WORD_W-1:0]  host_wdata_i,
    output logic [gemm_pkg::WORD_W-1:0]  host_rdata_o,
    input  logic                         dma_we_i,
    input  logic [gemm_pkg::MEM_AW-1:0]  dma_addr_i,
    input  gemm_pkg::mem_word_u          dma_wdata_i,
    output gemm_pkg::mem_word_u          dma_rdata_o
);
    import gemm_pkg::*;

    mem_word_u mem [MEM_DEPTH];
    logic      collide;

    // same word written by both ports in one cycle
    assign collide = host_we_i & dma_we_i & (host_addr_i == dma_addr_i);

    always_ff @(posedge clk) begin
        if (host_we_i && !collide)
            mem[host_addr_i] <= host_wdata_i;
        if (dma_we_i)
            mem[dma_addr_i] <= dma_wdata_i;
    end

    assign host_rdata_o = mem[host_addr_i];
    assign dma_rdata_o  = mem[dma_addr_i];

endmodule

/* dma/beat_counter.sv */
// ##########################################################
// beat index for DMA load and store phases
// last flag follows the phase length the FSM supplies
// ##########################################################
`timescale 1ns/1ns

module beat_counter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clear_i,
    input  logic                        step_i,
    input  logic [gemm_pkg::LEN_W-1:0]  length_i,
    output logic [gemm_pkg::IDX_W-1:0]  idx_o,
    output logic                        last_o
);
    import gemm_pkg::*;

    // clear beats step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            idx_o <= '0;
        else if (clear_i)
            idx_o <= '0;
        else if (step_i)
            idx_o <= idx_o + 1'b1;
    end

    assign last_o = ({1'b0, idx_o} == (length_i - 1'b1));

endmodule

/* dma/dma_ctrl_fsm.sv */
// ##########################################################
// DMA sequencer: load A rows, load B columns, kick the
// engine, wait, store C, then flag done for one cycle
// ##########################################################
`timescale 1ns/1ns

module dma_ctrl_fsm (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_i,
    input  logic [gemm_pkg::MEM_AW-1:0]  a_base_i,
    input  logic [gemm_pkg::MEM_AW-1:0]  b_base_i,
    input  logic [gemm_pkg::MEM_AW-1:0]  c_base_i,
    input  logic [gemm_pkg::IDX_W-1:0]   beat_idx_i,
    input  logic                         beat_last_i,
    output logic                         beat_clear_o,
    output logic                         beat_step_o,
    output logic [gemm_pkg::LEN_W-1:0]   beat_len_o,
    output logic [gemm_pkg::MEM_AW-1:0]  mem_addr_o,
    output logic                         mem_we_o,
    output logic                         buf_a_we_o,
    output logic                         buf_b_we_o,
    output logic                         mm_start_o,
    input  logic                         mm_done_i,
    output logic                         busy_o,
    output logic                         done_o
);
    import gemm_pkg::*;

    dma_state_e state, state_n;
    logic       in_phase;
    logic [MEM_AW-1:0] base;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            busy_o <= 1'b0;
        end else begin
            state <= state_n;
            if (state == IDLE && start_i)
                busy_o <= 1'b1;
            else if (state == FINISH)
                busy_o <= 1'b0;
        end
    end

    always_comb begin
        state_n = state;
        case (state)
            IDLE:     if (start_i) state_n = LOAD_A;
            LOAD_A:   if (beat_last_i) state_n = LOAD_B;
            LOAD_B:   if (beat_last_i) state_n = START_MM;
            START_MM: state_n = WAIT_MM;
            WAIT_MM:  if (mm_done_i) state_n = STORE_C;
            STORE_C:  if (beat_last_i) state_n = FINISH;
            FINISH:   state_n = IDLE;
            default:  state_n = IDLE;
        endcase
    end

    // beats only run in load and store phases
    assign in_phase     = (state == LOAD_A) | (state == LOAD_B) | (state == STORE_C);
    assign beat_step_o  = in_phase;
    // counter cleared outside phases and on each phase exit
    assign beat_clear_o = !in_phase | beat_last_i;
    assign beat_len_o   = (state == STORE_C) ? LEN_W'(NUM_RES) : LEN_W'(SA_WIDTH);

    // active base, word address wraps modulo 64
    always_comb begin
        case (state)
            LOAD_A:  base = a_base_i;
            LOAD_B:  base = b_base_i;
            default: base = c_base_i;
        endcase
    end
    assign mem_addr_o = base + MEM_AW'(beat_idx_i);

    assign mem_we_o   = (state == STORE_C);
    assign buf_a_we_o = (state == LOAD_A);
    assign buf_b_we_o = (state == LOAD_B);
    assign mm_start_o = (state == START_MM);
    assign done_o     = (state == FINISH);

endmodule

/* logic/operand_buffer.sv */
// ##########################################################
// four-word operand store, one word per DMA beat
// all words presented flat to the multiply engine
// ##########################################################
`timescale 1ns/1ns

module operand_buffer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we_i,
    input  logic [gemm_pkg::SEL_W-1:0]  waddr_i,
    input  gemm_pkg::mem_word_u         wdata_i,
    output logic [gemm_pkg::BUF_W-1:0]  words_o
);
    import gemm_pkg::*;

    mem_word_u words [SA_WIDTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < SA_WIDTH; k++)
                words[k] <= '0;
        end else if (we_i) begin
            words[waddr_i] <= wdata_i;
        end
    end

    // word 0 lands in the low bits
    always_comb begin
        for (int k = 0; k < SA_WIDTH; k++)
            words_o[k*WORD_W +: WORD_W] = words[k];
    end

endmodule

/* logic/mm_engine.sv */
// ##########################################################
// 4x4 int8 matrix multiply, one C element per cycle
// A rows and B columns come from the operand buffers
// results held until the DMA stores them
// ##########################################################
`timescale 1ns/1ns

module mm_engine (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_i,
    input  logic [gemm_pkg::BUF_W-1:0]  a_words_i,
    input  logic [gemm_pkg::BUF_W-1:0]  b_words_i,
    input  logic [gemm_pkg::IDX_W-1:0]  rd_idx_i,
    output logic                        done_o,
    output gemm_pkg::mem_word_u         rd_data_o
);
    import gemm_pkg::*;

    logic             running;
    logic [IDX_W-1:0] step;
    logic [SEL_W-1:0] row, col;
    mem_word_u        a_row, b_col, acc;
    mem_word_u        results [NUM_RES];

    // step = i*4 + j
    assign row = step[IDX_W-1:SEL_W];
    assign col = step[SEL_W-1:0];

    assign a_row = a_words_i[row*WORD_W +: WORD_W];
    assign b_col = b_words_i[col*WORD_W +: WORD_W];

    // four signed 8x8 products summed at 32 bits
    always_comb begin
        acc.res = '0;
        for (int k = 0; k < SA_WIDTH; k++)
            acc.res = acc.res + $signed(a_row.elem[k]) * $signed(b_col.elem[k]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            step    <= '0;
        end else if (start_i) begin
            running <= 1'b1;
            step    <= '0;
        end else if (running) begin
            step <= step + 1'b1;
            if (step == IDX_W'(NUM_RES - 1))
                running <= 1'b0;
        end
    end

    // result bank, no reset needed
    always_ff @(posedge clk) begin
        if (running)
            results[step] <= acc;
    end

    // high while the sixteenth result is written
    assign done_o    = running & (step == IDX_W'(NUM_RES - 1));
    assign rd_data_o = results[rd_idx_i];

endmodule

/* logic/gemm_top.sv */
// ##########################################################
// accelerator top: APB regs, scratch memory, DMA sequencer,
// operand buffers and the multiply engine
// ##########################################################
`timescale 1ns/1ns

module gemm_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [gemm_pkg::APB_AW-1:0] paddr_i,
    input  logic [gemm_pkg::WORD_W-1:0] pwdata_i,
    output logic [gemm_pkg::WORD_W-1:0] prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o
);
    import gemm_pkg::*;

    // host to memory
    logic              host_we;
    logic [MEM_AW-1:0] host_addr;
    logic [WORD_W-1:0] host_wdata, host_rdata;
    // control
    logic              start_pulse, busy, done_pulse;
    logic [MEM_AW-1:0] a_base, b_base, c_base;
    // DMA side
    logic              dma_we;
    logic [MEM_AW-1:0] dma_addr;
    mem_word_u         dma_wdata, dma_rdata;
    logic              beat_clear, beat_step, beat_last;
    logic [LEN_W-1:0]  beat_len;
    logic [IDX_W-1:0]  beat_idx;
    logic              buf_a_we, buf_b_we;
    logic [BUF_W-1:0]  a_words, b_words;
    logic              mm_start, mm_done;

    apb_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .host_we_o(host_we), .host_addr_o(host_addr),
        .host_wdata_o(host_wdata), .host_rdata_i(host_rdata),
        .start_o(start_pulse),
        .a_base_o(a_base), .b_base_o(b_base), .c_base_o(c_base),
        .busy_i(busy), .done_pulse_i(done_pulse)
    );

    scratch_mem u_mem (
        .clk(clk),
        .host_we_i(host_we), .host_addr_i(host_addr),
        .host_wdata_i(host_wdata), .host_rdata_o(host_rdata),
        .dma_we_i(dma_we), .dma_addr_i(dma_addr),
        .dma_wdata_i(dma_wdata), .dma_rdata_o(dma_rdata)
    );

    dma_ctrl_fsm u_fsm (
        .clk(clk), .rst_n(rst_n), .start_i(start_pulse),
        .a_base_i(a_base), .b_base_i(b_base), .c_base_i(c_base),
        .beat_idx_i(beat_idx), .beat_last_i(beat_last),
        .beat_clear_o(beat_clear), .beat_step_o(beat_step), .beat_len_o(beat_len),
        .mem_addr_o(dma_addr), .mem_we_o(dma_we),
        .buf_a_we_o(buf_a_we), .buf_b_we_o(buf_b_we),
        .mm_start_o(mm_start), .mm_done_i(mm_done),
        .busy_o(busy), .done_o(done_pulse)
    );

    beat_counter u_beats (
        .clk(clk), .rst_n(rst_n),
        .clear_i(beat_clear), .step_i(beat_step), .length_i(beat_len),
        .idx_o(beat_idx), .last_o(beat_last)
    );

    // A rows
    operand_buffer u_buf_a (
        .clk(clk), .rst_n(rst_n), .we_i(buf_a_we),
        .waddr_i(beat_idx[SEL_W-1:0]), .wdata_i(dma_rdata), .words_o(a_words)
    );

    // B columns
    operand_buffer u_buf_b (
        .clk(clk), .rst_n(rst_n), .we_i(buf_b_we),
        .waddr_i(beat_idx[SEL_W-1:0]), .wdata_i(dma_rdata), .words_o(b_words)
    );

    mm_engine u_mm (
        .clk(clk), .rst_n(rst_n), .start_i(mm_start),
        .a_words_i(a_words), .b_words_i(b_words),
        .rd_idx_i(beat_idx), .done_o(mm_done), .rd_data_o(dma_wdata)
    );

endmodule

/* tests/gemm_tb.sv */
// ##########################################################
// testbench for the gemm accelerator, driven over APB
// cases come from tests/gemm_cases.txt, expected C is built
// here from the signed dot-product rule
// ##########################################################
`timescale 1ns/1ns

module gemm_tb;
    import gemm_pkg::*;

    localparam int MAX_CASES  = 16;
    localparam int FIELDS     = 5;
    localparam int READY_WAIT = 8;
    localparam int POLL_LIMIT = 100;
    // start to idle: both loads, kick, multiply, store, finish
    localparam int RUN_CYCLES = 2*SA_WIDTH + 1 + 2*NUM_RES + 1;
    // setup, access and idle cycle of one apb transfer
    localparam int APB_CYCLES = 3;

    logic              clk;
    logic              rst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [WORD_W-1:0] pwdata;
    logic [WORD_W-1:0] prdata;
    logic              pready;
    logic              pslverr;

    // case table, five hex fields per case
    logic [7:0]        case_mem [MAX_CASES*FIELDS];
    logic [15:0]       lfsr;
    logic signed [7:0] a_m [SA_WIDTH][SA_WIDTH];
    logic signed [7:0] b_m [SA_WIDTH][SA_WIDTH];
    int                checks;
    int                errors;
    int                timeouts;
    // free running cycle count
    int                cyc;

    gemm_top dut (
        .clk(clk), .rst_n(rst_n),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
        cyc++;

    // x^16 + x^14 + x^13 + x^11 + 1, shifting right
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
    endfunction

    // one lfsr step per bit taken
    task automatic rand_byte(output logic [7:0] b);
        for (int n = 0; n < 8; n++) begin
            b[n] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // word addresses wrap modulo 64
    function automatic logic [MEM_AW-1:0] wrap_add(input logic [MEM_AW-1:0] base, input int off);
        return base + MEM_AW'(off);
    endfunction

    function automatic logic [APB_AW-1:0] win_addr(input logic [MEM_AW-1:0] word);
        return MEM_WIN_BASE + {{(APB_AW-MEM_AW-2){1'b0}}, word, 2'b00};
    endfunction

    task automatic check_word(input string name, input mem_word_u got, input mem_word_u exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
        end
    endtask

    // setup cycle, access cycle, sample mid-cycle, release
    task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                              input logic [WORD_W-1:0] wdata,
                              output logic [WORD_W-1:0] rdata, output logic err);
        int waited;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!pready && waited < READY_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            timeouts++;
            $display("pready never rose for address %h", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [WORD_W-1:0] data,
                             output logic err);
        logic [WORD_W-1:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [WORD_W-1:0] data,
                            output logic err);
        apb_access(1'b0, addr, '0, data, err);
    endtask

    // accesses that must not fault
    task automatic reg_write(input logic [APB_AW-1:0] addr, input logic [WORD_W-1:0] data);
        logic err;
        apb_write(addr, data, err);
        check_err($sformatf("pslverr on write %h", addr), err, 1'b0);
    endtask

    task automatic reg_read(input logic [APB_AW-1:0] addr, output logic [WORD_W-1:0] data);
        logic err;
        apb_read(addr, data, err);
        check_err($sformatf("pslverr on read %h", addr), err, 1'b0);
    endtask

    // poll until idle with done set
    task automatic wait_done();
        logic [WORD_W-1:0] st;
        int                polls;
        polls = 0;
        reg_read(REG_STATUS, st);
        while (st[1:0] != 2'b10 && polls < POLL_LIMIT) begin
            reg_read(REG_STATUS, st);
            polls++;
        end
        if (st[1:0] != 2'b10) begin
            timeouts++;
            $display("run did not finish within %0d status polls", polls);
        end
    endtask

    // operands for one case, chosen by pattern code
    task automatic make_operands(input logic [7:0] pat);
        for (int i = 0; i < SA_WIDTH; i++) begin
            for (int j = 0; j < SA_WIDTH; j++) begin
                case (pat)
                    8'h01: begin
                        a_m[i][j] = 8'sd127;
                        b_m[i][j] = 8'sd127;
                    end
                    8'h02: begin
                        a_m[i][j] = -8'sd128;
                        b_m[i][j] = -8'sd128;
                    end
                    8'h03: begin
                        a_m[i][j] = (i == j) ? 8'sd1 : 8'sd0;
                        rand_byte(b_m[i][j]);
                    end
                    default: begin
                        rand_byte(a_m[i][j]);
                        rand_byte(b_m[i][j]);
                    end
                endcase
            end
        end
    endtask

    // A row i and B column j as memory words
    function automatic mem_word_u a_row(input int i);
        mem_word_u w;
        for (int k = 0; k < SA_WIDTH; k++)
            w.elem[k] = a_m[i][k];
        return w;
    endfunction

    function automatic mem_word_u b_col(input int j);
        mem_word_u w;
        for (int k = 0; k < SA_WIDTH; k++)
            w.elem[k] = b_m[k][j];
        return w;
    endfunction

    task automatic check_operands(input logic [7:0] num, input logic [MEM_AW-1:0] a_base,
                                  input logic [MEM_AW-1:0] b_base);
        mem_word_u got;
        for (int i = 0; i < SA_WIDTH; i++) begin
            reg_read(win_addr(wrap_add(a_base, i)), got);
            check_word($sformatf("case %0d a word %0d", num, i), got, a_row(i));
            reg_read(win_addr(wrap_add(b_base, i)), got);
            check_word($sformatf("case %0d b word %0d", num, i), got, b_col(i));
        end
    endtask

    task automatic run_case(input int c);
        logic [7:0]        num;
        logic [7:0]        pat;
        logic [MEM_AW-1:0] a_base;
        logic [MEM_AW-1:0] b_base;
        logic [MEM_AW-1:0] c_base;
        logic [WORD_W-1:0] rd;
        logic              err;
        mem_word_u         got;
        mem_word_u         exp;
        int                sum;
        int                start_cyc;

        num    = case_mem[c*FIELDS];
        a_base = case_mem[c*FIELDS+1][MEM_AW-1:0];
        b_base = case_mem[c*FIELDS+2][MEM_AW-1:0];
        c_base = case_mem[c*FIELDS+3][MEM_AW-1:0];
        pat    = case_mem[c*FIELDS+4];
        make_operands(pat);

        for (int i = 0; i < SA_WIDTH; i++) begin
            reg_write(win_addr(wrap_add(a_base, i)), a_row(i));
            reg_write(win_addr(wrap_add(b_base, i)), b_col(i));
        end
        reg_write(REG_A_BASE, {26'd0, a_base});
        reg_write(REG_B_BASE, {26'd0, b_base});
        reg_write(REG_C_BASE, {26'd0, c_base});
        reg_write(REG_CTRL, 32'h1);
        start_cyc = cyc;

        // DMA owns memory now, done cleared by the start
        reg_read(REG_STATUS, rd);
        check_status($sformatf("case %0d status while busy", num), rd[1:0], 2'b01);
        apb_read(win_addr(c_base), rd, err);
        check_err($sformatf("case %0d pslverr window read busy", num), err, 1'b1);
        apb_write(win_addr(a_base), 32'hdead_beef, err);
        check_err($sformatf("case %0d pslverr window write busy", num), err, 1'b1);
        // second start lands while busy
        reg_write(REG_CTRL, 32'h1);
        wait_done();

        // done seen within two transfers of the end of the first run
        // a restarted run ends a whole run after the second start
        if (cyc - start_cyc > RUN_CYCLES + 2*APB_CYCLES) begin
            errors++;
            $display("case %0d: second start restarted the run, done after %0d cycles",
                     num, cyc - start_cyc);
        end

        for (int i = 0; i < SA_WIDTH; i++) begin
            for (int j = 0; j < SA_WIDTH; j++) begin
                sum = 0;
                for (int k = 0; k < SA_WIDTH; k++)
                    sum = sum + int'(a_m[i][k]) * int'(b_m[k][j]);
                exp.res = sum;
                reg_read(win_addr(wrap_add(c_base, i*SA_WIDTH + j)), got);
                check_word($sformatf("case %0d c[%0d][%0d]", num, i, j), got, exp);
            end
        end
        check_operands(num, a_base, b_base);
    endtask

    initial begin
        logic [WORD_W-1:0] rd;
        logic              err;
        int                n_cases;

        clk      = 1'b0;
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        cyc      = 0;
        lfsr     = 16'd58998;
        // ff marks the end of the table
        for (int k = 0; k < MAX_CASES*FIELDS; k++)
            case_mem[k] = 8'hff;
        $readmemh("tests/gemm_cases.txt", case_mem);

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset values
        reg_read(REG_STATUS, rd);
        check_word("status after reset", rd, 32'h0);
        reg_read(REG_A_BASE, rd);
        check_word("a_base after reset", rd, 32'h0);
        reg_read(REG_B_BASE, rd);
        check_word("b_base after reset", rd, 32'h0);
        reg_read(REG_C_BASE, rd);
        check_word("c_base after reset", rd, 32'h0);

        // bases keep 6 bits
        reg_write(REG_A_BASE, 32'h0000_07f5);
        reg_write(REG_B_BASE, 32'h0000_1c2a);
        reg_write(REG_C_BASE, 32'hffff_ffd1);
        reg_read(REG_A_BASE, rd);
        check_word("a_base masked", rd, 32'h35);
        reg_read(REG_B_BASE, rd);
        check_word("b_base masked", rd, 32'h2a);
        reg_read(REG_C_BASE, rd);
        check_word("c_base masked", rd, 32'h11);

        // unmapped and STATUS writes fault and leave state alone
        // 0x208 shares its low bits with A_BASE
        apb_read(12'h014, rd, err);
        check_err("pslverr unmapped read", err, 1'b1);
        apb_write(12'h208, 32'h3f, err);
        check_err("pslverr unmapped write", err, 1'b1);
        apb_write(12'h0fc, 32'h3f, err);
        check_err("pslverr write below window", err, 1'b1);
        apb_write(REG_STATUS, 32'h3, err);
        check_err("pslverr status write", err, 1'b1);
        reg_read(REG_STATUS, rd);
        check_word("status after faults", rd, 32'h0);
        reg_read(REG_A_BASE, rd);
        check_word("a_base after faults", rd, 32'h35);

        n_cases = 0;
        while (n_cases < MAX_CASES && case_mem[n_cases*FIELDS] !== 8'hff) begin
            run_case(n_cases);
            n_cases++;
        end
        if (n_cases == 0) begin
            errors++;
            $display("no test cases were read from tests/gemm_cases.txt");
        end

        $display("cases %0d, checks %0d, errors %0d, timeouts %0d",
                 n_cases, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* tests/gemm_cases.txt */
// columns: case a_base b_base c_base pattern, all hex word addresses
// pattern 0 random, 1 all +127, 2 all -128, 3 identity A with random B
01 00 04 08 0
02 10 14 20 1
03 00 04 08 2
04 30 34 08 3
05 3e 02 10 0
06 0c 10 3c 0
07 20 28 30 0
08 3c 38 00 0
09 3f 05 09 3
0a 18 1c 24 0
0b 2c 04 30 2
0c 08 3d 10 1

/* gemm_accel.f */
common/gemm_pkg.sv
logic/apb_regs.sv
logic/scratch_mem.sv
dma/beat_counter.sv
dma/dma_ctrl_fsm.sv
logic/operand_buffer.sv
logic/mm_engine.sv
logic/gemm_top.sv
tests/gemm_tb.sv
